// File: Makefile
VERILATOR  ?= verilator
TOP        ?= arena_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --timing --assert

SRCS := $(wildcard hw/*.sv tests/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/arena_geom_pkg.sv
`default_nettype none

package arena_geom_pkg;

  typedef logic [9:0] coord_t;

  // Clamp bounds for a fighter's x position.
  localparam coord_t ARENA_MIN_X = 10'd50;
  localparam coord_t ARENA_MAX_X = 10'd490;

  localparam coord_t START_X_LEFT  = 10'd210;
  localparam coord_t START_X_RIGHT = 10'd420;

  localparam coord_t SPRITE_W = 10'd150;

  // Box offsets from posx for the left side.
  localparam coord_t HIT_OFF1_L  = 10'd35;
  localparam coord_t HIT_OFF2_L  = 10'd113;
  localparam coord_t HURT_OFF1_L = 10'd37;
  localparam coord_t HURT_OFF2_L = 10'd86;

  // Right side is the left side mirrored inside the sprite.
  localparam coord_t HIT_OFF1_R  = SPRITE_W - HIT_OFF2_L;
  localparam coord_t HIT_OFF2_R  = SPRITE_W - HIT_OFF1_L;
  localparam coord_t HURT_OFF1_R = SPRITE_W - HURT_OFF2_L;
  localparam coord_t HURT_OFF2_R = SPRITE_W - HURT_OFF1_L;

  // Fixed rows; hitbox rows lie within the hurtbox rows.
  localparam coord_t FIGHTER_Y   = 10'd170;
  localparam coord_t HIT_Y1_OFF  = 10'd24;
  localparam coord_t HIT_Y2_OFF  = 10'd57;
  localparam coord_t HURT_Y1_OFF = 10'd0;
  localparam coord_t HURT_Y2_OFF = 10'd150;

endpackage

`default_nettype wire

// File: hw/arena_top.sv
`timescale 1ns/1ps
`default_nettype none

module arena_top
  import arena_geom_pkg::*;
  import fighter_pkg::*;
#(
  parameter int unsigned TICK_DIV   = 4,
  parameter health_t     HEALTH_MAX = 8'd10,
  parameter health_t     HIT_DAMAGE = 8'd3
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            left_l,
  input  wire            right_l,
  input  wire            attack_l,
  input  wire            left_r,
  input  wire            right_r,
  input  wire            attack_r,
  output coord_t         posx_l,
  output coord_t         posx_r,
  output fighter_state_t state_l,
  output fighter_state_t state_r,
  output logic           hit_l,
  output logic           hit_r,
  output health_t        health_l,
  output health_t        health_r,
  output logic           game_over
);

  logic   frame_tick;
  logic   hit_active_l;
  logic   hit_active_r;
  coord_t hit_x1_l;
  coord_t hit_x2_l;
  coord_t hurt_x1_l;
  coord_t hurt_x2_l;
  coord_t hit_x1_r;
  coord_t hit_x2_r;
  coord_t hurt_x1_r;
  coord_t hurt_x2_r;

  frame_timer #(
    .TICK_DIV(TICK_DIV)
  ) frame_timer_inst (
    .clk       (clk),
    .rst       (rst),
    .frame_tick(frame_tick)
  );

  fighter #(
    .SIDE(1'b0)
  ) fighter_l_inst (
    .clk       (clk),
    .rst       (rst),
    .frame_tick(frame_tick),
    .game_over (game_over),
    .left      (left_l),
    .right     (right_l),
    .attack    (attack_l),
    .posx      (posx_l),
    .state     (state_l),
    .hit_active(hit_active_l),
    .hit_x1    (hit_x1_l),
    .hit_x2    (hit_x2_l),
    .hurt_x1   (hurt_x1_l),
    .hurt_x2   (hurt_x2_l)
  );

  fighter #(
    .SIDE(1'b1)
  ) fighter_r_inst (
    .clk       (clk),
    .rst       (rst),
    .frame_tick(frame_tick),
    .game_over (game_over),
    .left      (left_r),
    .right     (right_r),
    .attack    (attack_r),
    .posx      (posx_r),
    .state     (state_r),
    .hit_active(hit_active_r),
    .hit_x1    (hit_x1_r),
    .hit_x2    (hit_x2_r),
    .hurt_x1   (hurt_x1_r),
    .hurt_x2   (hurt_x2_r)
  );

  // Left attacks against right's hurtbox.
  hit_detect hit_detect_l_inst (
    .clk       (clk),
    .rst       (rst),
    .hit_active(hit_active_l),
    .hit_x1    (hit_x1_l),
    .hit_x2    (hit_x2_l),
    .hurt_x1   (hurt_x1_r),
    .hurt_x2   (hurt_x2_r),
    .hit       (hit_l)
  );

  hit_detect hit_detect_r_inst (
    .clk       (clk),
    .rst       (rst),
    .hit_active(hit_active_r),
    .hit_x1    (hit_x1_r),
    .hit_x2    (hit_x2_r),
    .hurt_x1   (hurt_x1_l),
    .hurt_x2   (hurt_x2_l),
    .hit       (hit_r)
  );

  health_tracker #(
    .HEALTH_MAX(HEALTH_MAX),
    .HIT_DAMAGE(HIT_DAMAGE)
  ) health_tracker_inst (
    .clk         (clk),
    .rst         (rst),
    .hit_by_left (hit_l),
    .hit_by_right(hit_r),
    .health_left (health_l),
    .health_right(health_r),
    .game_over   (game_over)
  );

endmodule

`default_nettype wire

// File: hw/fighter.sv
`timescale 1ns/1ps
`default_nettype none

module fighter
  import arena_geom_pkg::*;
  import fighter_pkg::*;
#(
  parameter bit SIDE = 1'b0
) (
  input  wire            clk,
  input  wire            rst,
  input  wire            frame_tick,
  input  wire            game_over,
  input  wire            left,
  input  wire            right,
  input  wire            attack,
  output coord_t         posx,
  output fighter_state_t state,
  output logic           hit_active,
  output coord_t         hit_x1,
  output coord_t         hit_x2,
  output coord_t         hurt_x1,
  output coord_t         hurt_x2
);

  localparam coord_t START_X = SIDE ? START_X_RIGHT : START_X_LEFT;

  localparam coord_t STEP_FWD = coord_t'(SPEED_FORWARD);
  localparam coord_t STEP_BWD = coord_t'(SPEED_BACKWARD);

  localparam coord_t HIT_OFF1  = SIDE ? HIT_OFF1_R : HIT_OFF1_L;
  localparam coord_t HIT_OFF2  = SIDE ? HIT_OFF2_R : HIT_OFF2_L;
  localparam coord_t HURT_OFF1 = SIDE ? HURT_OFF1_R : HURT_OFF1_L;
  localparam coord_t HURT_OFF2 = SIDE ? HURT_OFF2_R : HURT_OFF2_L;

  // Last tick count of each attack phase.
  localparam tick_cnt_t START_LAST   = ATK_START_TICKS - 5'd1;
  localparam tick_cnt_t ACTIVE_LAST  = ATK_ACTIVE_TICKS - 5'd1;
  localparam tick_cnt_t RECOVER_LAST = ATK_RECOVER_TICKS - 5'd1;
  localparam tick_cnt_t TICK_CNT_MAX = '1;

  fighter_state_t next_state;
  tick_cnt_t      tick_cnt;
  coord_t         step_posx;
  coord_t         next_posx;
  logic           advance;

  // Input decision, used in the movement states and after recovery.
  function automatic fighter_state_t decide(input logic l, input logic r, input logic a);
    fighter_state_t res;
    if (a) begin
      res = ST_ATK_START;
    end else if (l && r) begin
      res = ST_BACKWARD;
    end else if (r) begin
      res = (SIDE == 1'b0) ? ST_FORWARD : ST_BACKWARD;
    end else if (l) begin
      res = (SIDE == 1'b0) ? ST_BACKWARD : ST_FORWARD;
    end else begin
      res = ST_IDLE;
    end
    return res;
  endfunction

  // Nothing moves once the round is over.
  assign advance = frame_tick && !game_over;

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE, ST_FORWARD, ST_BACKWARD: begin
        next_state = decide(left, right, attack);
      end
      ST_ATK_START: begin
        if (tick_cnt >= START_LAST) begin
          next_state = ST_ATK_ACTIVE;
        end
      end
      ST_ATK_ACTIVE: begin
        if (tick_cnt >= ACTIVE_LAST) begin
          next_state = ST_ATK_RECOVER;
        end
      end
      ST_ATK_RECOVER: begin
        if (tick_cnt >= RECOVER_LAST) begin
          next_state = decide(left, right, attack);
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  // Forward is toward the opponent, so the sign flips with the side.
  always_comb begin
    case (next_state)
      ST_FORWARD:  step_posx = (SIDE == 1'b0) ? posx + STEP_FWD : posx - STEP_FWD;
      ST_BACKWARD: step_posx = (SIDE == 1'b0) ? posx - STEP_BWD : posx + STEP_BWD;
      default:     step_posx = posx;
    endcase
    if (step_posx < ARENA_MIN_X) begin
      next_posx = ARENA_MIN_X;
    end else if (step_posx > ARENA_MAX_X) begin
      next_posx = ARENA_MAX_X;
    end else begin
      next_posx = step_posx;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      posx     <= START_X;
    end else if (advance) begin
      state <= next_state;
      posx  <= next_posx;
      // Counter restarts on entry to a new state and saturates.
      if (next_state != state) begin
        tick_cnt <= '0;
      end else if (tick_cnt != TICK_CNT_MAX) begin
        tick_cnt <= tick_cnt + 5'd1;
      end
    end
  end

  assign hit_active = (state == ST_ATK_ACTIVE);

  assign hit_x1  = posx + HIT_OFF1;
  assign hit_x2  = posx + HIT_OFF2;
  assign hurt_x1 = posx + HURT_OFF1;
  assign hurt_x2 = posx + HURT_OFF2;

endmodule

`default_nettype wire

// File: hw/fighter_pkg.sv
`default_nettype none

package fighter_pkg;

  typedef enum logic [2:0] {
    ST_IDLE        = 3'd0,
    ST_FORWARD     = 3'd1,
    ST_BACKWARD    = 3'd2,
    ST_ATK_START   = 3'd3,
    ST_ATK_ACTIVE  = 3'd4,
    ST_ATK_RECOVER = 3'd5
  } fighter_state_t;

  // Frame ticks spent in the current state.
  typedef logic [4:0] tick_cnt_t;

  typedef logic [7:0] health_t;

  // Pixels per frame tick.
  localparam int unsigned SPEED_FORWARD  = 3;
  localparam int unsigned SPEED_BACKWARD = 2;

  // Attack phase lengths in frame ticks.
  localparam tick_cnt_t ATK_START_TICKS   = 5'd5;
  localparam tick_cnt_t ATK_ACTIVE_TICKS  = 5'd2;
  localparam tick_cnt_t ATK_RECOVER_TICKS = 5'd16;

endpackage

`default_nettype wire

// File: hw/frame_timer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_timer #(
  parameter int unsigned TICK_DIV = 4
) (
  input  wire  clk,
  input  wire  rst,
  output logic frame_tick
);

  localparam int unsigned CW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam logic [CW-1:0] LAST = CW'(TICK_DIV - 1);

  logic [CW-1:0] cnt;

  // Wraps after the last count of each frame.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (cnt == LAST) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign frame_tick = (cnt == LAST);

endmodule

`default_nettype wire

// File: hw/health_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module health_tracker
  import fighter_pkg::*;
#(
  parameter health_t HEALTH_MAX = 8'd10,
  parameter health_t HIT_DAMAGE = 8'd3
) (
  input  wire     clk,
  input  wire     rst,
  input  wire     hit_by_left,
  input  wire     hit_by_right,
  output health_t health_left,
  output health_t health_right,
  output logic    game_over
);

  health_t left_dmg;
  health_t right_dmg;

  // Damage saturates at zero.
  assign left_dmg  = (health_left > HIT_DAMAGE) ? health_left - HIT_DAMAGE : '0;
  assign right_dmg = (health_right > HIT_DAMAGE) ? health_right - HIT_DAMAGE : '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      health_left  <= HEALTH_MAX;
      health_right <= HEALTH_MAX;
    end else begin
      if (hit_by_left) begin
        health_right <= right_dmg;
      end
      if (hit_by_right) begin
        health_left <= left_dmg;
      end
    end
  end

  // Sticky until reset.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      game_over <= 1'b0;
    end else if (health_left == '0 || health_right == '0) begin
      game_over <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/hit_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hit_detect
  import arena_geom_pkg::*;
(
  input  wire    clk,
  input  wire    rst,
  input  wire    hit_active,
  input  coord_t hit_x1,
  input  coord_t hit_x2,
  input  coord_t hurt_x1,
  input  coord_t hurt_x2,
  output logic   hit
);

  logic active_q;
  logic active_rise;
  logic overlap;

  // Ranges share at least one pixel.
  assign overlap = (hit_x1 <= hurt_x2) && (hurt_x1 <= hit_x2);

  // Only the first cycle of the active phase can score.
  assign active_rise = hit_active && !active_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      active_q <= 1'b0;
      hit      <= 1'b0;
    end else begin
      active_q <= hit_active;
      hit      <= active_rise && overlap;
    end
  end

endmodule

`default_nettype wire

// File: list.f
hw/arena_geom_pkg.sv
hw/fighter_pkg.sv
hw/frame_timer.sv
hw/fighter.sv
hw/hit_detect.sv
hw/health_tracker.sv
hw/arena_top.sv
tests/arena_checker.sv
tests/arena_tb.sv

// File: tests/arena_checker.sv
`timescale 1ns/1ps
`default_nettype none

module arena_checker
  import arena_geom_pkg::*;
  import fighter_pkg::*;
(
  input wire                 clk,
  input wire                 rst,
  input wire                 frame_tick,
  input wire                 game_over,
  input wire coord_t         posx,
  input wire fighter_state_t state,
  input wire                 hit_active
);

  // Clamp keeps the fighter on screen.
  posx_in_arena: assert property (@(posedge clk) disable iff (rst)
    posx >= ARENA_MIN_X && posx <= ARENA_MAX_X)
    else $error("posx %0d outside the arena", posx);

  // State only moves on a frame tick.
  state_on_tick: assert property (@(posedge clk) disable iff (rst)
    !frame_tick |=> $stable(state))
    else $error("state changed outside a frame tick");

  active_matches_state: assert property (@(posedge clk) disable iff (rst)
    hit_active == (state == ST_ATK_ACTIVE))
    else $error("hit_active disagrees with the state");

  // Round over, nothing moves.
  frozen_after_ko: assert property (@(posedge clk) disable iff (rst)
    game_over |=> $stable(posx) && $stable(state))
    else $error("fighter moved after game over");

endmodule

bind fighter arena_checker fighter_checker_inst (
  .clk       (clk),
  .rst       (rst),
  .frame_tick(frame_tick),
  .game_over (game_over),
  .posx      (posx),
  .state     (state),
  .hit_active(hit_active)
);

`default_nettype wire

// File: tests/arena_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arena_tb
  import arena_geom_pkg::*;
  import fighter_pkg::*;
();

  localparam int TICK_DIV    = 4;
  localparam int FULL_HEALTH = 10;
  localparam int DAMAGE      = 3;
  localparam int STIM_TICKS  = 3000;
  localparam int ROUND_TICKS = 500;
  localparam int MAX_CYCLES  = 30000;

  logic           clk;
  logic           rst;
  logic           left_l;
  logic           right_l;
  logic           attack_l;
  logic           left_r;
  logic           right_r;
  logic           attack_r;
  coord_t         posx_l;
  coord_t         posx_r;
  fighter_state_t state_l;
  fighter_state_t state_r;
  logic           hit_l;
  logic           hit_r;
  health_t        health_l;
  health_t        health_r;
  logic           game_over;

  // Model state with the left fighter at index 0.
  int             m_div;
  fighter_state_t m_state [2];
  int             m_ticks [2];
  int             m_posx [2];
  logic           m_active_q [2];
  logic           m_hit [2];
  int             m_health [2];
  logic           m_go;
  int             errors = 0;
  int             hit_count = 0;
  int             cycles = 0;
  int             rounds = 0;

  arena_top #(
    .TICK_DIV  (TICK_DIV),
    .HEALTH_MAX(8'd10),
    .HIT_DAMAGE(8'd3)
  ) arena_top_inst (
    .clk      (clk),
    .rst      (rst),
    .left_l   (left_l),
    .right_l  (right_l),
    .attack_l (attack_l),
    .left_r   (left_r),
    .right_r  (right_r),
    .attack_r (attack_r),
    .posx_l   (posx_l),
    .posx_r   (posx_r),
    .state_l  (state_l),
    .state_r  (state_r),
    .hit_l    (hit_l),
    .hit_r    (hit_r),
    .health_l (health_l),
    .health_r (health_r),
    .game_over(game_over)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic fighter_state_t choose_state(input int side, input logic l,
                                                  input logic r, input logic a);
    if (a) begin
      return ST_ATK_START;
    end else if (l && r) begin
      return ST_BACKWARD;
    end else if (r) begin
      return (side == 0) ? ST_FORWARD : ST_BACKWARD;
    end else if (l) begin
      return (side == 0) ? ST_BACKWARD : ST_FORWARD;
    end
    return ST_IDLE;
  endfunction

  function automatic int phase_len(input fighter_state_t s);
    case (s)
      ST_ATK_START:   return 5;
      ST_ATK_ACTIVE:  return 2;
      ST_ATK_RECOVER: return 16;
      default:        return 0;
    endcase
  endfunction

  // Attacker hitbox against the other fighter's hurtbox.
  function automatic logic boxes_overlap(input int att, input int pa, input int pd);
    int h1;
    int h2;
    int u1;
    int u2;
    h1 = pa + ((att == 0) ? 35 : 37);
    h2 = pa + ((att == 0) ? 113 : 115);
    u1 = pd + ((att == 0) ? 64 : 37);
    u2 = pd + ((att == 0) ? 113 : 86);
    return (h1 <= u2) && (u1 <= h2);
  endfunction

  function automatic int drain(input int h);
    int rest;
    rest = h - DAMAGE;
    if (rest < 0) begin
      rest = 0;
    end
    return rest;
  endfunction

  task automatic reset_model();
    int i;
    m_div = 0;
    m_go  = 1'b0;
    m_posx[0] = int'(START_X_LEFT);
    m_posx[1] = int'(START_X_RIGHT);
    for (i = 0; i < 2; i++) begin
      m_state[i]    = ST_IDLE;
      m_ticks[i]    = 0;
      m_active_q[i] = 1'b0;
      m_hit[i]      = 1'b0;
      m_health[i]   = FULL_HEALTH;
    end
  endtask

  task automatic step_fighter(input int i, input logic l, input logic r, input logic a);
    fighter_state_t nxt;
    int             pos;
    nxt = m_state[i];
    if (phase_len(m_state[i]) == 0) begin
      nxt = choose_state(i, l, r, a);
    end else if (m_ticks[i] + 1 >= phase_len(m_state[i])) begin
      case (m_state[i])
        ST_ATK_START:  nxt = ST_ATK_ACTIVE;
        ST_ATK_ACTIVE: nxt = ST_ATK_RECOVER;
        default:       nxt = choose_state(i, l, r, a);
      endcase
    end
    pos = m_posx[i];
    if (nxt == ST_FORWARD) begin
      pos = (i == 0) ? pos + 3 : pos - 3;
    end else if (nxt == ST_BACKWARD) begin
      pos = (i == 0) ? pos - 2 : pos + 2;
    end
    if (pos < int'(ARENA_MIN_X)) pos = int'(ARENA_MIN_X);
    if (pos > int'(ARENA_MAX_X)) pos = int'(ARENA_MAX_X);
    m_ticks[i] = (nxt != m_state[i]) ? 0 : m_ticks[i] + 1;
    m_state[i] = nxt;
    m_posx[i]  = pos;
  endtask

  // One clock edge of the whole arena from values before the edge.
  task automatic step_model();
    logic tick;
    logic go_next;
    logic act [2];
    logic ovl [2];
    int   i;
    tick    = (m_div == TICK_DIV - 1);
    m_div   = tick ? 0 : m_div + 1;
    go_next = m_go || m_health[0] == 0 || m_health[1] == 0;
    if (m_hit[0]) m_health[1] = drain(m_health[1]);
    if (m_hit[1]) m_health[0] = drain(m_health[0]);
    for (i = 0; i < 2; i++) begin
      act[i] = (m_state[i] == ST_ATK_ACTIVE);
    end
    ovl[0] = boxes_overlap(0, m_posx[0], m_posx[1]);
    ovl[1] = boxes_overlap(1, m_posx[1], m_posx[0]);
    if (tick && !m_go) begin
      step_fighter(0, left_l, right_l, attack_l);
      step_fighter(1, left_r, right_r, attack_r);
    end
    for (i = 0; i < 2; i++) begin
      m_hit[i]      = act[i] && !m_active_q[i] && ovl[i];
      m_active_q[i] = act[i];
    end
    m_go = go_next;
  endtask

  task automatic check_value(input string name, input int dut, input int exp);
    assert (dut == exp) else begin
      errors++;
      $display("Mismatch at %0t: %s is %0d, model has %0d", $time, name, dut, exp);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      reset_model();
    end else begin
      step_model();
    end
    #1;
    check_value("posx_l", int'(posx_l), m_posx[0]);
    check_value("posx_r", int'(posx_r), m_posx[1]);
    check_value("state_l", int'(state_l), int'(m_state[0]));
    check_value("state_r", int'(state_r), int'(m_state[1]));
    check_value("hit_l", int'(hit_l), int'(m_hit[0]));
    check_value("hit_r", int'(hit_r), int'(m_hit[1]));
    check_value("health_l", int'(health_l), m_health[0]);
    check_value("health_r", int'(health_r), m_health[1]);
    check_value("game_over", int'(game_over), int'(m_go));
    if (hit_l) hit_count++;
    if (hit_r) hit_count++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles, %0d errors", cycles, errors);
      $display("Finished with errors");
      $finish;
    end
  end

  // Picks the inputs of one fighter and how many ticks they last.
  task automatic pick_inputs(input int side, output int len);
    int   dir;
    int   gap;
    logic fwd;
    logic bwd;
    logic both;
    logic atk;
    gap = int'(posx_r) - int'(posx_l);
    dir = $urandom_range(7);
    atk = ($urandom_range(7) == 0);
    // Close in while far apart.
    if (gap > 40 && dir >= 5 && dir <= 6) dir = dir - 3;
    fwd  = (dir >= 2 && dir <= 4);
    bwd  = (dir >= 5 && dir <= 6);
    both = (dir == 7);
    len  = $urandom_range(40, 1);
    if (side == 0) begin
      left_l   = bwd || both;
      right_l  = fwd || both;
      attack_l = atk;
    end else begin
      left_r   = fwd || both;
      right_r  = bwd || both;
      attack_r = atk;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    rst      = 1'b1;
    left_l   = 1'b0;
    right_l  = 1'b0;
    attack_l = 1'b0;
    left_r   = 1'b0;
    right_r  = 1'b0;
    attack_r = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic run_round(inout int ticks_done);
    int ticks;
    int go_ticks;
    int seg_l;
    int seg_r;
    ticks    = 0;
    go_ticks = 0;
    seg_l    = 0;
    seg_r    = 0;
    while (ticks < ROUND_TICKS && go_ticks < 20 && ticks_done < STIM_TICKS) begin
      if (seg_l == 0) pick_inputs(0, seg_l);
      if (seg_r == 0) pick_inputs(1, seg_r);
      repeat (TICK_DIV) @(negedge clk);
      seg_l--;
      seg_r--;
      ticks++;
      ticks_done++;
      if (game_over) go_ticks++;
    end
  endtask

  initial begin
    int ticks_done;
    rst      = 1'b1;
    left_l   = 1'b0;
    right_l  = 1'b0;
    attack_l = 1'b0;
    left_r   = 1'b0;
    right_r  = 1'b0;
    attack_r = 1'b0;
    void'($urandom(82));
    ticks_done = 0;
    while (ticks_done < STIM_TICKS) begin
      apply_reset();
      run_round(ticks_done);
      rounds++;
    end
    repeat (4) @(negedge clk);
    $display("Errors: %0d, hits: %0d, rounds: %0d", errors, hit_count, rounds);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
